// ==== logic/eth_rx_pkg.sv ====
package eth_rx_pkg;

  typedef logic [7:0]  octet_t;
  typedef logic [31:0] word_t;      // first octet of a word in [31:24]
  typedef logic [8:0]  buf_addr_t;  // 512-word packet buffer
  typedef logic [10:0] frame_len_t; // octets, fcs excluded
  typedef logic [3:0]  apb_addr_t;

  // one decoded bit from the line, valid for a single cycle
  typedef struct packed {
    logic valid;
    logic value;
  } bit_beat_t;

  typedef enum logic [1:0] {
    IDLE,
    PREAMBLE,
    BODY,
    BLOCKED
  } frame_state_t;

  // ieee 802.3 crc-32, shifted lsb first
  localparam word_t CRC_POLY    = 32'hEDB8_8320; // reflected polynomial
  localparam word_t CRC_RESIDUE = 32'hDEBB_20E3; // register after data plus fcs

  localparam apb_addr_t REG_STATUS = 4'h0;
  localparam apb_addr_t REG_LEN    = 4'h4;
  localparam apb_addr_t REG_DROPS  = 4'h8;

endpackage

// ==== logic/manchester_decoder.sv ====
`timescale 1ns/1ps

module manchester_decoder #(
  parameter int SAMPLES_PER_BIT = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  line,
  output eth_rx_pkg::bit_beat_t beat,
  output logic                  line_lost
);

  localparam int ACCEPT_TIME = (3 * SAMPLES_PER_BIT) / 4;
  localparam int LOST_TIME   = (5 * SAMPLES_PER_BIT) / 2;
  localparam int TW          = $clog2(LOST_TIME + 1);

  logic          sync1;
  logic          sync2;
  logic          level_q;   // previous synchronized level
  logic [TW-1:0] timer;     // cycles since last accepted transition
  logic          edge_seen;
  logic          accept;

  assign edge_seen = sync2 ^ level_q;
  // transitions closer than 3/4 bit are bit-boundary transitions
  assign accept = edge_seen && (timer >= TW'(ACCEPT_TIME));

  // synchronizer keeps tracking the wire during reset
  always_ff @(posedge CLK)
  begin
    sync1   <= line;
    sync2   <= sync1;
    level_q <= sync2;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      timer      <= TW'(LOST_TIME); // start as if the line were idle
      beat.valid <= 1'b0;
      beat.value <= 1'b0;
      line_lost  <= 1'b0;
    end
    else
    begin
      beat.valid <= accept;
      beat.value <= sync2;        // new level, rising means 1
      line_lost  <= !accept && (timer == TW'(LOST_TIME - 1));

      if (accept)
        timer <= '0;
      else if (timer != TW'(LOST_TIME))
        timer <= timer + 1'b1;    // saturates, so line_lost fires once
    end
  end

  // a bit and a carrier loss can never be reported together
  a_beat_vs_lost: assert property (
    @(posedge CLK) disable iff (!RST)
    beat.valid |-> !line_lost
  ) else $error("beat and line_lost pulsed in the same cycle");

endmodule

// ==== logic/frame_control.sv ====
`timescale 1ns/1ps

module frame_control #(
  parameter int PREAMBLE_MIN = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  eth_rx_pkg::bit_beat_t beat,
  input  logic                  line_lost,
  input  logic                  busy,
  output logic                  in_frame,
  output logic                  frame_start,
  output logic                  frame_end,
  output logic                  drop_pulse
);

  localparam int CW = $clog2(PREAMBLE_MIN + 1);

  eth_rx_pkg::frame_state_t state;
  logic [CW-1:0]            pre_count;  // preamble beats, saturating
  logic                     prev_bit;
  logic                     sfd_seen;
  logic                     frame_open;

  // delimiter ends in two ones after a long enough preamble
  assign sfd_seen = beat.valid && beat.value && prev_bit &&
                    (pre_count >= CW'(PREAMBLE_MIN));

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state       <= eth_rx_pkg::IDLE;
      pre_count   <= '0;
      prev_bit    <= 1'b0;
      in_frame    <= 1'b0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      drop_pulse  <= 1'b0;
      frame_open  <= 1'b0;
    end
    else
    begin
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      drop_pulse  <= 1'b0;

      if (beat.valid)
        prev_bit <= beat.value;
      else if (line_lost)
        prev_bit <= 1'b0;   // fresh start for the next carrier

      case (state)
        eth_rx_pkg::IDLE:
          if (beat.valid)
          begin
            pre_count <= CW'(1);
            state     <= busy ? eth_rx_pkg::BLOCKED : eth_rx_pkg::PREAMBLE;
          end
        eth_rx_pkg::PREAMBLE:
          if (line_lost)
            state <= eth_rx_pkg::IDLE;
          else if (sfd_seen)
          begin
            state       <= eth_rx_pkg::BODY;
            in_frame    <= 1'b1;
            frame_start <= 1'b1;
          end
          else if (beat.valid && pre_count != CW'(PREAMBLE_MIN))
            pre_count <= pre_count + 1'b1;
        eth_rx_pkg::BODY:
          if (line_lost)
          begin
            state     <= eth_rx_pkg::IDLE;
            in_frame  <= 1'b0;
            frame_end <= 1'b1;
          end
        default:  // BLOCKED, wait out the carrier
          if (line_lost)
          begin
            state      <= eth_rx_pkg::IDLE;
            drop_pulse <= 1'b1;
          end
      endcase

      if (frame_start)
        frame_open <= 1'b1;
      else if (frame_end)
        frame_open <= 1'b0;
    end
  end

  a_start_needs_end: assert property (
    @(posedge CLK) disable iff (!RST)
    frame_start |-> !frame_open
  ) else $error("frame_start repeated without frame_end");

endmodule

// ==== logic/octet_collector.sv ====
`timescale 1ns/1ps

module octet_collector (
  input  logic                  CLK,
  input  logic                  RST,
  input  eth_rx_pkg::bit_beat_t beat,
  input  logic                  in_frame,
  input  logic                  frame_start,
  output eth_rx_pkg::octet_t    octet,
  output logic                  octet_valid,
  output logic                  aligned
);

  logic [2:0] bit_count;
  logic       take;

  assign take    = in_frame && beat.valid;
  assign aligned = (bit_count == 3'd0);

  // lsb first, first bit lands in bit 0 after eight shifts
  always_ff @(posedge CLK)
  begin
    if (take)
      octet <= {beat.value, octet[7:1]};
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      bit_count   <= 3'd0;
      octet_valid <= 1'b0;
    end
    else
    begin
      octet_valid <= take && (bit_count == 3'd7);
      if (frame_start)
        bit_count <= 3'd0;
      else if (take)
        bit_count <= bit_count + 3'd1;  // wraps every octet
    end
  end

endmodule

// ==== logic/crc32_check.sv ====
`timescale 1ns/1ps

module crc32_check (
  input  logic                  CLK,
  input  logic                  RST,
  input  eth_rx_pkg::bit_beat_t beat,
  input  logic                  in_frame,
  input  logic                  frame_start,
  output logic                  crc_ok
);

  eth_rx_pkg::word_t crc;
  logic              feedback;

  assign feedback = crc[0] ^ beat.value;

  // fcs bits go through too, so a clean frame leaves the residue
  assign crc_ok = (crc == eth_rx_pkg::CRC_RESIDUE);

  always_ff @(posedge CLK)
  begin
    if (!RST)
      crc <= '1;
    else if (frame_start)
      crc <= '1;              // preset per frame
    else if (in_frame && beat.valid)
      crc <= (crc >> 1) ^ ({32{feedback}} & eth_rx_pkg::CRC_POLY);
  end

endmodule

// ==== logic/word_packer.sv ====
`timescale 1ns/1ps

module word_packer (
  input  logic                   CLK,
  input  logic                   RST,
  input  eth_rx_pkg::octet_t     octet,
  input  logic                   octet_valid,
  input  logic                   aligned,
  input  logic                   crc_ok,
  input  logic                   frame_start,
  input  logic                   frame_end,
  output eth_rx_pkg::buf_addr_t  buf_addr,
  output eth_rx_pkg::word_t      buf_data,
  output logic                   buf_write,
  output logic                   frame_done,
  output logic                   frame_good,
  output eth_rx_pkg::frame_len_t frame_len
);

  logic [1:0]             byte_idx;     // next byte lane, 0 is the top byte
  eth_rx_pkg::frame_len_t octet_count;
  logic                   active;       // between frame_start and frame_end
  logic                   take;

  assign take = octet_valid && active;

  always_ff @(posedge CLK)
  begin
    if (take)
    begin
      case (byte_idx)
        2'd0:    buf_data[31:24] <= octet;
        2'd1:    buf_data[23:16] <= octet;
        2'd2:    buf_data[15:8]  <= octet;
        default: buf_data[7:0]   <= octet;
      endcase
    end
    if (frame_end)
      frame_len <= octet_count - eth_rx_pkg::frame_len_t'(4);  // drop the fcs
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      byte_idx    <= 2'd0;
      octet_count <= '0;
      active      <= 1'b0;
      buf_addr    <= '0;
      buf_write   <= 1'b0;
      frame_done  <= 1'b0;
      frame_good  <= 1'b0;
    end
    else
    begin
      buf_write  <= take && (byte_idx == 2'd3);  // partial words never written
      frame_done <= frame_end;

      if (frame_start)
      begin
        active      <= 1'b1;
        byte_idx    <= 2'd0;
        octet_count <= '0;
        buf_addr    <= '0;
      end
      else
      begin
        if (take)
        begin
          byte_idx    <= byte_idx + 2'd1;
          octet_count <= octet_count + 1'b1;
        end
        if (buf_write)
          buf_addr <= buf_addr + 1'b1;
        if (frame_end)
          active <= 1'b0;
      end

      if (frame_end)
        frame_good <= crc_ok && aligned &&
                      (octet_count >= eth_rx_pkg::frame_len_t'(4));
    end
  end

  // the last word must be out before the frame closes
  a_write_in_frame: assert property (
    @(posedge CLK) disable iff (!RST)
    $rose(buf_write) |-> active
  ) else $error("buffer write outside a frame");

endmodule

// ==== logic/rx_apb_regs.sv ====
`timescale 1ns/1ps

module rx_apb_regs (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  eth_rx_pkg::apb_addr_t  paddr,
  input  eth_rx_pkg::word_t      pwdata,
  input  logic                   frame_done,
  input  logic                   frame_good,
  input  eth_rx_pkg::frame_len_t frame_len,
  input  logic                   drop_pulse,
  output eth_rx_pkg::word_t      prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   busy
);

  logic                   ready;      // good frame waiting in the buffer
  eth_rx_pkg::frame_len_t len_reg;
  logic [15:0]            drops;
  logic                   access_wr;
  logic                   drop_event;

  assign access_wr  = psel && penable && pwrite;
  assign drop_event = (frame_done && !frame_good) || drop_pulse;

  assign pready  = 1'b1;   // zero wait states
  assign pslverr = 1'b0;
  assign busy    = ready;

  always_comb
  begin
    case (paddr)
      eth_rx_pkg::REG_STATUS: prdata = {31'b0, ready};
      eth_rx_pkg::REG_LEN:    prdata = {21'b0, len_reg};
      eth_rx_pkg::REG_DROPS:  prdata = {16'b0, drops};
      default:                prdata = '0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      ready   <= 1'b0;
      len_reg <= '0;
      drops   <= '0;
    end
    else
    begin
      if (access_wr && paddr == eth_rx_pkg::REG_STATUS && pwdata[0])
        ready <= 1'b0;    // host releases the buffer
      if (frame_done && frame_good)
      begin
        ready   <= 1'b1;
        len_reg <= frame_len;
      end
      if (drop_event && drops != '1)
        drops <= drops + 16'd1;  // sticks at max
    end
  end

endmodule

// ==== logic/eth_rx_top.sv ====
`timescale 1ns/1ps

module eth_rx_top #(
  parameter int SAMPLES_PER_BIT = 8,
  parameter int PREAMBLE_MIN    = 8
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  line,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  eth_rx_pkg::apb_addr_t paddr,
  input  eth_rx_pkg::word_t     pwdata,
  output eth_rx_pkg::buf_addr_t buf_addr,
  output eth_rx_pkg::word_t     buf_data,
  output logic                  buf_write,
  output eth_rx_pkg::word_t     prdata,
  output logic                  pready,
  output logic                  pslverr
);

  eth_rx_pkg::bit_beat_t  beat;
  logic                   line_lost;
  logic                   in_frame;
  logic                   frame_start;
  logic                   frame_end;
  logic                   drop_pulse;
  eth_rx_pkg::octet_t     octet;
  logic                   octet_valid;
  logic                   aligned;
  logic                   crc_ok;
  logic                   frame_done;
  logic                   frame_good;
  eth_rx_pkg::frame_len_t frame_len;
  logic                   busy;

  manchester_decoder #(
    .SAMPLES_PER_BIT(SAMPLES_PER_BIT)
  ) u_decoder (
    .CLK       (CLK),
    .RST       (RST),
    .line      (line),
    .beat      (beat),
    .line_lost (line_lost)
  );

  frame_control #(
    .PREAMBLE_MIN(PREAMBLE_MIN)
  ) u_frame_ctl (
    .CLK         (CLK),
    .RST         (RST),
    .beat        (beat),
    .line_lost   (line_lost),
    .busy        (busy),
    .in_frame    (in_frame),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .drop_pulse  (drop_pulse)
  );

  octet_collector u_collector (
    .CLK         (CLK),
    .RST         (RST),
    .beat        (beat),
    .in_frame    (in_frame),
    .frame_start (frame_start),
    .octet       (octet),
    .octet_valid (octet_valid),
    .aligned     (aligned)
  );

  crc32_check u_crc (
    .CLK         (CLK),
    .RST         (RST),
    .beat        (beat),
    .in_frame    (in_frame),
    .frame_start (frame_start),
    .crc_ok      (crc_ok)
  );

  word_packer u_packer (
    .CLK         (CLK),
    .RST         (RST),
    .octet       (octet),
    .octet_valid (octet_valid),
    .aligned     (aligned),
    .crc_ok      (crc_ok),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .buf_addr    (buf_addr),
    .buf_data    (buf_data),
    .buf_write   (buf_write),
    .frame_done  (frame_done),
    .frame_good  (frame_good),
    .frame_len   (frame_len)
  );

  rx_apb_regs u_regs (
    .CLK        (CLK),
    .RST        (RST),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .frame_done (frame_done),
    .frame_good (frame_good),
    .frame_len  (frame_len),
    .drop_pulse (drop_pulse),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .busy       (busy)
  );

endmodule

// ==== test/eth_rx_checker.sv ====
`timescale 1ns/1ps

module eth_rx_checker (
  input  logic                  CLK,
  input  eth_rx_pkg::buf_addr_t buf_addr,
  input  eth_rx_pkg::word_t     buf_data,
  input  logic                  buf_write,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  eth_rx_pkg::apb_addr_t paddr,
  input  eth_rx_pkg::word_t     prdata,
  input  logic                  pready,
  input  logic                  pslverr,
  input  int                    row_id,
  input  logic                  row_open,
  input  logic                  wr_check,
  input  int                    exp_count,
  input  eth_rx_pkg::word_t     exp_words [0:31],
  input  logic                  rd_check,
  input  eth_rx_pkg::word_t     rd_exp,
  output int                    checks,
  output int                    errors
);

  int   wr_idx = 0;        // next expected buffer word
  int   row_checks = 0;
  int   row_errors = 0;
  int   check_total = 0;
  int   error_total = 0;
  logic open_q = 1'b0;

  assign checks = check_total;
  assign errors = error_total;

  function automatic string reg_name(input eth_rx_pkg::apb_addr_t addr);
    case (addr)
      eth_rx_pkg::REG_STATUS: return "STATUS";
      eth_rx_pkg::REG_LEN:    return "LEN";
      eth_rx_pkg::REG_DROPS:  return "DROPS";
      default:                return "unmapped register";
    endcase
  endfunction

  task automatic compare(input string name, input eth_rx_pkg::word_t exp,
                         input eth_rx_pkg::word_t got);
    row_checks++;
    if (got !== exp)
    begin
      row_errors++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  // mid-cycle sampling, all DUT outputs and tb drives are settled here
  always @(negedge CLK)
  begin
    if (row_open && !open_q)
    begin
      wr_idx = 0;
      row_checks = 0;
      row_errors = 0;
    end
    if (row_open && wr_check && buf_write)
    begin
      if (wr_idx < exp_count)
      begin
        compare("buf_addr", eth_rx_pkg::word_t'(wr_idx), eth_rx_pkg::word_t'(buf_addr));
        compare("buf_data", exp_words[wr_idx], buf_data);
      end
      else
      begin
        row_checks++;
        row_errors++;
        $display("row %0d: unexpected buffer write to address %0d at %0d ns",
                 row_id, buf_addr, $time);
      end
      wr_idx++;
    end
    if (row_open && psel && penable)
    begin
      compare("pready", 32'h1, eth_rx_pkg::word_t'(pready));  // no wait states
      compare("pslverr", 32'h0, eth_rx_pkg::word_t'(pslverr));
    end
    if (row_open && rd_check && psel && penable && !pwrite)
      compare(reg_name(paddr), rd_exp, prdata);   // access phase of a read
    if (!row_open && open_q)
    begin
      if (wr_check)
        compare("write count", eth_rx_pkg::word_t'(exp_count), eth_rx_pkg::word_t'(wr_idx));
      $display("row %0d finished: %0d checks, %0d errors", row_id, row_checks, row_errors);
      check_total += row_checks;
      error_total += row_errors;
    end
    open_q = row_open;
  end

endmodule

// ==== test/eth_rx_tb.sv ====
`timescale 1ns/1ps

module eth_rx_tb;

  localparam int NROWS      = 8;
  localparam int HALF_BIT   = 4;    // clocks per half bit at 8 samples per bit
  localparam int POLL_LIMIT = 60;

  typedef struct packed {
    int   len;      // payload octets
    logic bad_fcs;
    int   extra;    // trailing bits after the fcs
    logic busy;     // previous good frame still unreleased
  } row_t;

  logic                  CLK = 1'b0;
  logic                  RST;
  logic                  line;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  eth_rx_pkg::apb_addr_t paddr;
  eth_rx_pkg::word_t     pwdata;
  eth_rx_pkg::buf_addr_t buf_addr;
  eth_rx_pkg::word_t     buf_data;
  logic                  buf_write;
  eth_rx_pkg::word_t     prdata;
  logic                  pready;
  logic                  pslverr;

  row_t               rows [0:NROWS-1];
  eth_rx_pkg::octet_t frame_q [$];
  eth_rx_pkg::word_t  exp_words [0:31];
  int                 row_id;
  logic               row_open;
  logic               wr_check;
  int                 exp_count;
  logic               rd_check;
  eth_rx_pkg::word_t  rd_exp;
  int                 checks;
  int                 errors;
  int                 failures;
  int                 seed;
  int                 drops_exp;
  int                 last_len;
  logic               good;
  logic               hold;
  logic               next_busy;

  always #10 CLK = ~CLK;

  eth_rx_top #(
    .SAMPLES_PER_BIT(8),
    .PREAMBLE_MIN(8)
  ) DUT (
    .CLK(CLK), .RST(RST), .line(line),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .buf_addr(buf_addr), .buf_data(buf_data), .buf_write(buf_write),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  eth_rx_checker u_checker (
    .CLK(CLK), .buf_addr(buf_addr), .buf_data(buf_data), .buf_write(buf_write),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .prdata(prdata),
    .pready(pready), .pslverr(pslverr),
    .row_id(row_id), .row_open(row_open), .wr_check(wr_check), .exp_count(exp_count),
    .exp_words(exp_words), .rd_check(rd_check), .rd_exp(rd_exp),
    .checks(checks), .errors(errors)
  );

  function automatic eth_rx_pkg::word_t crc_step(input eth_rx_pkg::word_t crc,
                                                 input eth_rx_pkg::octet_t d);
    eth_rx_pkg::word_t c;
    c = crc;
    for (int b = 0; b < 8; b++)
      c = (c >> 1) ^ ((c[0] ^ d[b]) ? 32'hEDB8_8320 : 32'h0);  // 802.3, lsb first
    return c;
  endfunction

  task automatic half_bit(input logic level);
    line = level;
    repeat (HALF_BIT) @(posedge CLK);
    #1;
  endtask

  task automatic send_bit(input logic b);
    half_bit(!b);   // a 1 is low then high
    half_bit(b);
  endtask

  task automatic send_octet(input eth_rx_pkg::octet_t o);
    for (int b = 0; b < 8; b++)
      send_bit(o[b]);
  endtask

  task automatic build_frame(input row_t row);
    eth_rx_pkg::word_t crc;
    logic [31:0]       rnd;
    crc = '1;
    frame_q.delete();
    for (int i = 0; i < row.len; i++)
    begin
      rnd = $random(seed);
      frame_q.push_back(rnd[7:0]);
      crc = crc_step(crc, rnd[7:0]);
    end
    crc = ~crc;
    if (row.bad_fcs)
      crc[31] = !crc[31];
    for (int i = 0; i < 4; i++)
      frame_q.push_back(crc[8*i +: 8]);   // fcs low byte first
    for (int i = 0; i < frame_q.size() / 4; i++)
      exp_words[i] = {frame_q[4*i], frame_q[4*i+1], frame_q[4*i+2], frame_q[4*i+3]};
  endtask

  task automatic send_frame(input int extra);
    @(posedge CLK);
    #1;
    for (int i = 0; i < 7; i++)
      send_octet(8'h55);
    send_octet(8'hD5);   // delimiter
    foreach (frame_q[i])
      send_octet(frame_q[i]);
    for (int i = 0; i < extra; i++)
      send_bit(i[0]);
    line = 1'b0;         // idle until carrier loss
  endtask

  task automatic apb_read(input eth_rx_pkg::apb_addr_t addr, output eth_rx_pkg::word_t data);
    @(posedge CLK);
    #1;
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(negedge CLK);
    data = prdata;
    @(posedge CLK);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input eth_rx_pkg::apb_addr_t addr, input eth_rx_pkg::word_t data);
    @(posedge CLK);
    #1;
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(posedge CLK);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic checked_read(input eth_rx_pkg::apb_addr_t addr, input int value);
    eth_rx_pkg::word_t data;
    rd_exp = value;
    rd_check = 1'b1;
    apb_read(addr, data);
    rd_check = 1'b0;
  endtask

  task automatic poll_reg(input eth_rx_pkg::apb_addr_t addr, input int value,
                          input string name);
    eth_rx_pkg::word_t data;
    int                tries;
    tries = 0;
    do
    begin
      apb_read(addr, data);
      tries++;
    end
    while (data !== value && tries < POLL_LIMIT);
    if (data !== value)
    begin
      failures++;
      $display("row %0d: gave up waiting for %s to read %0d", row_id, name, value);
    end
  endtask

  task automatic open_row(input int id, input logic check_writes, input int count);
    row_id = id;
    wr_check = check_writes;
    exp_count = count;
    row_open = 1'b1;
  endtask

  task automatic close_row();
    row_open = 1'b0;
    @(posedge CLK);
    #1;
  endtask

  initial
  begin
    RST = 1'b0;
    line = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    row_id = 0;
    row_open = 1'b0;
    wr_check = 1'b0;
    exp_count = 0;
    rd_check = 1'b0;
    rd_exp = '0;
    failures = 0;
    seed = 12;
    drops_exp = 0;
    last_len = 0;
    foreach (exp_words[i])
      exp_words[i] = '0;
    rows[0] = '{len: 8,  bad_fcs: 1'b0, extra: 0, busy: 1'b0};
    rows[1] = '{len: 16, bad_fcs: 1'b0, extra: 0, busy: 1'b0};
    rows[2] = '{len: 60, bad_fcs: 1'b0, extra: 0, busy: 1'b0};
    rows[3] = '{len: 20, bad_fcs: 1'b1, extra: 0, busy: 1'b0};
    rows[4] = '{len: 12, bad_fcs: 1'b0, extra: 3, busy: 1'b0};
    rows[5] = '{len: 8,  bad_fcs: 1'b0, extra: 0, busy: 1'b0};
    rows[6] = '{len: 16, bad_fcs: 1'b0, extra: 0, busy: 1'b1};
    rows[7] = '{len: 10, bad_fcs: 1'b0, extra: 0, busy: 1'b0};
    repeat (3) @(posedge CLK);
    #1;
    RST = 1'b1;

    // registers clear and no writes on an idle line
    open_row(0, 1'b1, 0);
    checked_read(eth_rx_pkg::REG_STATUS, 0);
    checked_read(eth_rx_pkg::REG_LEN, 0);
    checked_read(eth_rx_pkg::REG_DROPS, 0);
    repeat (40) @(posedge CLK);
    close_row();

    for (int r = 0; r < NROWS; r++)
    begin
      good = !rows[r].bad_fcs && rows[r].extra == 0 && !rows[r].busy;
      hold = good || rows[r].busy;   // a good frame waits in the buffer
      if (r + 1 < NROWS)
        next_busy = rows[r + 1].busy;
      else
        next_busy = 1'b0;
      build_frame(rows[r]);
      open_row(r + 1, hold, good ? frame_q.size() / 4 : 0);
      send_frame(rows[r].extra);
      if (good)
      begin
        last_len = rows[r].len;
        poll_reg(eth_rx_pkg::REG_STATUS, 1, "STATUS");
      end
      else
      begin
        drops_exp++;
        poll_reg(eth_rx_pkg::REG_DROPS, drops_exp, "DROPS");
      end
      checked_read(eth_rx_pkg::REG_STATUS, hold ? 1 : 0);
      checked_read(eth_rx_pkg::REG_LEN, last_len);
      checked_read(eth_rx_pkg::REG_DROPS, drops_exp);
      if (hold && !next_busy)
      begin
        apb_write(eth_rx_pkg::REG_STATUS, 32'h1);   // release the buffer
        checked_read(eth_rx_pkg::REG_STATUS, 0);
      end
      close_row();
    end

    @(posedge CLK);
    $display("%0d rows, %0d checks, %0d errors, %0d other failures",
             NROWS + 1, checks, errors, failures);
    if (errors == 0 && failures == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
logic/eth_rx_pkg.sv
logic/manchester_decoder.sv
logic/frame_control.sv
logic/octet_collector.sv
logic/crc32_check.sv
logic/word_packer.sv
logic/rx_apb_regs.sv
logic/eth_rx_top.sv
test/eth_rx_checker.sv
test/eth_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module eth_rx_tb -f src.f -o eth_rx_sim || exit 1
./obj_dir/eth_rx_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
